/* dv/eth_tx_mac_checker.sv */
`timescale 1ns/1ns

module eth_tx_mac_checker (
    input logic                   clk,
    input logic                   reset_n,
    input eth_tx_pkg::byte_beat_t i_line,
    input logic                   i_line_ready,
    input logic                   i_payload_ready,
    input logic                   i_hdr_ready,
    input logic [2:0]             i_fsm_state     // Framer state register
);
    import eth_tx_pkg::*;

    localparam logic [2:0] GAP_STATE = 3'd5;        // Encoding of GAP in the framer
    localparam int         MIN_GAP   = 12;          // Shortest gap over all link speeds

    int         fail_cnt     = 0;                   // Read by the testbench at the end
    logic       reset_seen_q = 1'b0;                // Reset held across one edge already
    logic       armed_q      = 1'b0;                // Frame ended, no byte sent since
    logic [4:0] idle_q       = '0;

    always_ff @(posedge clk) begin
        reset_seen_q <= reset_n;
        if (reset_n) begin
            armed_q <= 1'b0;
        end else if (i_fsm_state == GAP_STATE && i_line.valid && i_line_ready) begin
            armed_q <= 1'b1;                        // Last FCS byte leaves on this edge
            idle_q  <= '0;
        end else if (i_line.valid) begin
            armed_q <= 1'b0;
        end else if (idle_q != '1) begin
            idle_q <= idle_q + 5'd1;                // Saturates, only the minimum matters
        end
    end

    // A stalled byte stays on the line until the PHY takes it
    a_line_hold: assert property (@(posedge clk) disable iff (reset_n)
        i_line.valid && !i_line_ready |=> i_line.valid && $stable(i_line.data))
        else begin $error("line byte changed while stalled"); fail_cnt++; end

    a_reset_ready: assert property (@(posedge clk)
        reset_n && reset_seen_q |-> !i_payload_ready && !i_hdr_ready)
        else begin $error("ready raised during reset"); fail_cnt++; end

    a_min_gap: assert property (@(posedge clk) disable iff (reset_n)
        armed_q && i_line.valid |-> idle_q >= MIN_GAP)
        else begin $error("next frame began inside the gap"); fail_cnt++; end

endmodule

/* dv/tb_eth_tx_mac.sv */
`timescale 1ns/1ns

module tb_eth_tx_mac;
    import eth_tx_pkg::*;

    localparam int NUM_TESTS = 10;
    localparam int MAX_LEN   = 256;

    typedef struct packed {
        logic [7:0]  len;                           // Payload bytes before padding
        link_speed_t speed;
        hdr_word_t   hdr;
        logic        bp;                            // Random stalls on the line side
    } test_row_t;

    // Rows sharing a speed run back to back so the DUT alone enforces the gap
    localparam test_row_t ROWS [NUM_TESTS] = '{
        '{8'd20,  2'd2, 64'h0030_1F2E_001C_3D4C, 1'b0}, // Short frame with 40 pad bytes
        '{8'd100, 2'd2, 64'h0060_A5C3_004C_7E19, 1'b0}, // Long frame without padding
        '{8'd64,  2'd2, 64'h0032_BEEF_001E_CAFE, 1'b0}, // All four fields inside the payload
        '{8'd64,  2'd2, 64'h0032_BEEF_001E_CAFE, 1'b1}, // Same frame under back-pressure
        '{8'd60,  2'd3, 64'h002E_1234_001A_5678, 1'b0}, // Exactly the minimum
        '{8'd59,  2'd3, 64'h002D_9ABC_0019_DEF0, 1'b1}, // One pad byte
        '{8'd46,  2'd1, 64'h0020_4455_000C_6677, 1'b0},
        '{8'd50,  2'd1, 64'h0024_8899_0010_AABB, 1'b1},
        '{8'd30,  2'd0, 64'h0010_CCDD_0000_EEFF, 1'b0}, // 10M gap of 1200 cycles
        '{8'd45,  2'd0, 64'h001F_0102_000B_0304, 1'b0}
    };

    logic        clk;
    logic        reset_n;
    byte_beat_t  payload;
    logic        payload_ready;
    hdr_word_t   hdr;
    logic        hdr_valid;
    logic        hdr_ready;
    link_speed_t link_speed;
    byte_beat_t  line;
    logic        line_ready;

    logic [31:0] bp_state;                          // Xorshift state of the stall pattern
    logic        bp_on;
    logic [7:0]  pay [MAX_LEN];                     // Raw payload of the current row
    logic [7:0]  exp_q [$];                         // Bytes still due on the line
    int          errors;
    int          fails;
    int          rx_idx;                            // Position inside the current frame
    logic        in_gap;
    int          idle_cnt;
    int          gap_need;

    eth_tx_mac #(
        .INSERT_HEADERS (1)
    ) DUT (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_payload       (payload),
        .o_payload_ready (payload_ready),
        .i_hdr           (hdr),
        .i_hdr_valid     (hdr_valid),
        .o_hdr_ready     (hdr_ready),
        .i_link_speed    (link_speed),
        .o_line          (line),
        .i_line_ready    (line_ready)
    );

    bind eth_tx_mac eth_tx_mac_checker u_checker (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_line          (o_line),
        .i_line_ready    (i_line_ready),
        .i_payload_ready (o_payload_ready),
        .i_hdr_ready     (o_hdr_ready),
        .i_fsm_state     (u_frame_fsm.state_q)
    );

    always #20 clk = ~clk;                          // 40 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Ethernet CRC-32 taken one data bit at a time with LSB first
    function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    // Header fields replace payload bytes with the high byte first
    function automatic logic [7:0] inserted_byte(input hdr_word_t h, input int k,
                                                 input logic [7:0] raw);
        case (k)
            IP_LEN_OFS:       return h.ip_len[15:8];
            IP_LEN_OFS + 1:   return h.ip_len[7:0];
            IP_CSUM_OFS:      return h.ip_csum[15:8];
            IP_CSUM_OFS + 1:  return h.ip_csum[7:0];
            UDP_LEN_OFS:      return h.udp_len[15:8];
            UDP_LEN_OFS + 1:  return h.udp_len[7:0];
            UDP_CSUM_OFS:     return h.udp_csum[15:8];
            UDP_CSUM_OFS + 1: return h.udp_csum[7:0];
            default:          return raw;
        endcase
    endfunction

    task automatic build_expected(input test_row_t row);
        logic [31:0] crc;
        logic [7:0]  b;
        int          body;
        crc  = CRC_INIT;
        body = (row.len < MIN_PAYLOAD_LEN) ? MIN_PAYLOAD_LEN : row.len; // Pad up to 60
        repeat (PREAMBLE_LEN) exp_q.push_back(ETH_PREAMBLE);
        exp_q.push_back(ETH_SFD);
        for (int k = 0; k < body; k++) begin
            b   = (k < row.len) ? inserted_byte(row.hdr, k, pay[k]) : ETH_PAD;
            crc = crc_next(crc, b);                 // FCS covers payload and pad only
            exp_q.push_back(b);
        end
        crc = ~crc;
        for (int i = 0; i < FCS_LEN; i++) begin
            exp_q.push_back(crc[8*i +: 8]);         // Least significant byte first
        end
    endtask

    //////////////////////////////
    // Drivers and monitor
    //////////////////////////////

    // Called on a falling edge and looks at ready once the drives have settled
    task automatic send_header(input hdr_word_t h);
        hdr       = h;
        hdr_valid = 1'b1;
        #1;
        while (!hdr_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);                             // Transfer took place on the rising edge
        hdr_valid = 1'b0;
    endtask

    task automatic send_payload(input int len);
        for (int k = 0; k < len; k++) begin
            payload = '{data: pay[k], last: (k == len - 1), valid: 1'b1};
            #1;
            while (!payload_ready) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        payload = '0;
    endtask

    always @(negedge clk) begin
        bp_state   = xorshift(bp_state);
        line_ready = bp_on ? |bp_state[4:3] : 1'b1; // Ready about three beats in four
    end

    // Looks at the beat that the next rising edge will complete
    always @(negedge clk) begin
        logic [7:0] want;
        #1;
        if (!reset_n && line.valid) begin
            if (in_gap && idle_cnt < gap_need) begin
                $display("Inter-frame gap of %0d idle cycles is shorter than %0d at %0t",
                         idle_cnt, gap_need, $time);
                errors++;
            end
            in_gap = 1'b0;
            if (line_ready && exp_q.size() == 0) begin
                $display("Line sent byte %02h at %0t with no frame expected", line.data, $time);
                errors++;
            end else if (line_ready) begin
                want = exp_q.pop_front();
                if (line.data !== want) begin
                    $display("ERR %0t: frame byte %0d is %02h, expected %02h",
                             $time, rx_idx, line.data, want);
                    errors++;
                end
                if (line.last !== 1'b0) begin
                    $display("ERR %0t: frame byte %0d has last set on the line, expected 0",
                             $time, rx_idx);
                    errors++;
                end
                rx_idx++;
                if (exp_q.size() == 0) begin        // Last FCS byte so the gap starts here
                    in_gap   = 1'b1;
                    idle_cnt = 0;
                    gap_need = gap_table[link_speed];
                    rx_idx   = 0;
                end
            end
        end else if (in_gap) begin
            idle_cnt++;
        end
    end

    // Budget of payload, framing and the longest gap per row taken four times
    initial begin
        int limit;
        limit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += ROWS[t].len + 80 + 1200;
        end
        repeat (limit * 4) @(posedge clk);
        $display("Timeout: the frames did not finish within %0d clock cycles", limit * 4);
        $display("Test failures found");
        $finish;
    end

    initial begin
        test_row_t   row;
        logic [31:0] pay_state;
        int          row_errs;
        clk        = 1'b0;
        reset_n    = 1'b1;                          // Held in reset while high
        payload    = '0;
        hdr        = '0;
        hdr_valid  = 1'b0;
        link_speed = ROWS[0].speed;
        line_ready = 1'b1;
        bp_on      = 1'b0;
        bp_state   = 32'd43;
        errors     = 0;
        fails      = 0;
        rx_idx     = 0;
        in_gap     = 1'b0;
        idle_cnt   = 0;
        gap_need   = 0;
        repeat (10) @(negedge clk);
        reset_n = 1'b0;
        repeat (2) @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            row      = ROWS[t];
            row_errs = errors;
            if (row.speed != link_speed) begin
                repeat (gap_table[link_speed] + 4) @(negedge clk); // Let the old gap run out
                link_speed = row.speed;
                repeat (2) @(negedge clk);
            end
            bp_on     = row.bp;
            pay_state = 32'd43;                     // Same lengths give the same payload
            for (int i = 0; i < row.len; i++) begin
                pay_state = xorshift(pay_state);
                pay[i]    = pay_state[7:0];
            end
            build_expected(row);
            send_header(row.hdr);
            send_payload(row.len);
            while (exp_q.size() != 0) @(negedge clk);
            if (errors != row_errs) begin
                fails++;
            end
            $display("test %0d: len %0d, speed %0d, back-pressure %0d, %s", t, row.len,
                     row.speed, row.bp, (errors == row_errs) ? "PASS" : "FAIL");
        end
        repeat (20) @(negedge clk);
        errors += DUT.u_checker.fail_cnt;           // Assertion failures count as errors
        $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
                 NUM_TESTS - fails, fails, errors);
        if (fails == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* rtl/eth_crc32.sv */
`timescale 1ns/1ns

module eth_crc32 (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_start,   // Reload the start value next edge
    input  logic                          i_update,  // Fold i_byte into the state
    input  logic [eth_tx_pkg::BYTE_W-1:0] i_byte,
    output logic [31:0]                   o_fcs      // Complemented state, LSB goes out first
);
    import eth_tx_pkg::*;

    logic [31:0] crc_q;                               // Running remainder

    // One byte of the bit serial LFSR, LSB of the data enters first
    function automatic logic [31:0] crc_byte_step(input logic [31:0] crc,
                                                  input logic [BYTE_W-1:0] data);
        logic [31:0] c;
        c = crc ^ {{(32 - BYTE_W){1'b0}}, data};
        for (int i = 0; i < BYTE_W; i++) begin
            c = {1'b0, c[31:1]} ^ (c[0] ? CRC_POLY : 32'h0); // Shift right, fold poly on carry
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_n || i_start) begin
            crc_q <= CRC_INIT;                        // Every frame starts from all ones
        end else if (i_update) begin
            crc_q <= crc_byte_step(crc_q, i_byte);
        end
    end

    // Final complement of the Ethernet FCS
    assign o_fcs = ~crc_q;

endmodule

/* rtl/eth_tx_mac.sv */
`timescale 1ns/1ns

module eth_tx_mac #(
    parameter int INSERT_HEADERS = 1                // Overwrite IP and UDP length and checksum
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  eth_tx_pkg::byte_beat_t  i_payload,
    output logic                    o_payload_ready,
    input  eth_tx_pkg::hdr_word_t   i_hdr,
    input  logic                    i_hdr_valid,
    output logic                    o_hdr_ready,
    input  eth_tx_pkg::link_speed_t i_link_speed,
    output eth_tx_pkg::byte_beat_t  o_line,
    input  logic                    i_line_ready
);
    import eth_tx_pkg::*;

    logic              hdr_take;
    logic              hdr_held;
    hdr_word_t         hdr_word;                    // Header word waiting for the next frame
    logic [GAP_W-1:0]  gap_len;
    logic [31:0]       fcs;
    logic              crc_start;
    logic              crc_update;
    logic [BYTE_W-1:0] crc_byte;

    // Header holding register and gap length lookup
    tx_hdr_config #(
        .INSERT_HEADERS (INSERT_HEADERS)
    ) u_hdr_config (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_hdr        (i_hdr),
        .i_hdr_valid  (i_hdr_valid),
        .o_hdr_ready  (o_hdr_ready),
        .i_hdr_take   (hdr_take),
        .o_hdr_held   (hdr_held),
        .o_hdr        (hdr_word),
        .i_link_speed (i_link_speed),
        .o_gap_len    (gap_len)
    );

    tx_frame_fsm #(
        .INSERT_HEADERS (INSERT_HEADERS)
    ) u_frame_fsm (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_payload       (i_payload),
        .o_payload_ready (o_payload_ready),
        .i_hdr_held      (hdr_held),
        .i_hdr           (hdr_word),
        .o_hdr_take      (hdr_take),
        .i_gap_len       (gap_len),
        .i_fcs           (fcs),
        .o_crc_start     (crc_start),
        .o_crc_update    (crc_update),
        .o_crc_byte      (crc_byte),
        .o_line          (o_line),
        .i_line_ready    (i_line_ready)
    );

    eth_crc32 u_crc32 (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_start  (crc_start),
        .i_update (crc_update),
        .i_byte   (crc_byte),
        .o_fcs    (fcs)
    );

endmodule

/* rtl/eth_tx_pkg.sv */
package eth_tx_pkg;

    //////////////////////////////
    // Frame layout
    //////////////////////////////

    localparam int BYTE_W = 8;                      // Line and payload beat width

    localparam logic [BYTE_W-1:0] ETH_PREAMBLE = 8'h55; // Repeated PREAMBLE_LEN times
    localparam logic [BYTE_W-1:0] ETH_SFD      = 8'hD5; // Start frame delimiter
    localparam logic [BYTE_W-1:0] ETH_PAD      = 8'h00; // Fill byte up to the minimum size

    localparam int PREAMBLE_LEN    = 7;
    localparam int MIN_PAYLOAD_LEN = 60;            // Payload plus pad, FCS not included
    localparam int FCS_LEN         = 4;

    // Offsets of the high byte of each late inserted field, from the first payload byte
    localparam int IP_LEN_OFS   = 16;
    localparam int IP_CSUM_OFS  = 24;
    localparam int UDP_LEN_OFS  = 38;
    localparam int UDP_CSUM_OFS = 40;

    // Reflected Ethernet CRC-32
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    //////////////////////////////
    // Inter-frame gap
    //////////////////////////////

    localparam int GAP_W = 11;                      // Holds the 1200 cycle gap at 10 Mb/s

    // Idle cycles per link speed code, entry 0 sits in the low word
    localparam logic [3:0][GAP_W-1:0] gap_table = {11'd12, 11'd12, 11'd120, 11'd1200};

    typedef logic [1:0] link_speed_t;               // 0 is 10M, 1 is 100M, 2 and 3 are 1G

    // One byte beat, last only carries meaning on the payload side
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              last;
        logic              valid;
    } byte_beat_t;

    // Values computed upstream while the payload streams in
    typedef struct packed {
        logic [15:0] ip_len;
        logic [15:0] ip_csum;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } hdr_word_t;

endpackage

/* rtl/tx_frame_fsm.sv */
`timescale 1ns/1ns

module tx_frame_fsm #(
    parameter int INSERT_HEADERS = 1
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  eth_tx_pkg::byte_beat_t        i_payload,
    output logic                          o_payload_ready,
    input  logic                          i_hdr_held,   // A header word is waiting
    input  eth_tx_pkg::hdr_word_t         i_hdr,
    output logic                          o_hdr_take,
    input  logic [eth_tx_pkg::GAP_W-1:0]  i_gap_len,
    input  logic [31:0]                   i_fcs,
    output logic                          o_crc_start,
    output logic                          o_crc_update,
    output logic [eth_tx_pkg::BYTE_W-1:0] o_crc_byte,
    output eth_tx_pkg::byte_beat_t        o_line,
    input  logic                          i_line_ready
);
    import eth_tx_pkg::*;

    localparam int CNT_W = $clog2(MIN_PAYLOAD_LEN + 1); // Counts to 60, saturates there

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,                                   // Seven 0x55 bytes then the SFD
        PAYLOAD,
        PAD,
        FCS,
        GAP
    } state_t;

    state_t            state_q;
    logic [CNT_W-1:0]  cnt_q;                        // Preamble, payload and FCS byte index
    logic [GAP_W-1:0]  gap_q;                        // Idle cycles seen in GAP
    logic [BYTE_W-1:0] line_data_q;
    logic              line_valid_q;
    hdr_word_t         hdr_q;                        // Frame copy of the header word
    logic              adv;                          // Output register free or draining
    logic              start;
    logic              pay_hs;
    logic [BYTE_W-1:0] pay_byte;                     // Payload byte after substitution

    //////////////////////////////
    // Handshakes and strobes
    //////////////////////////////

    assign adv             = !line_valid_q || i_line_ready;
    assign start           = (state_q == IDLE) && i_payload.valid && i_hdr_held;
    assign o_payload_ready = (state_q == PAYLOAD) && adv;
    assign pay_hs          = o_payload_ready && i_payload.valid;

    assign o_hdr_take  = start;                      // Frees the config register for the next word
    assign o_crc_start = start;

    // CRC sees exactly what goes on the line between SFD and FCS
    assign o_crc_update = pay_hs || ((state_q == PAD) && adv);
    assign o_crc_byte   = (state_q == PAD) ? ETH_PAD : pay_byte;

    assign o_line = '{data: line_data_q, last: 1'b0, valid: line_valid_q};

    // Late header insertion, high byte first
    // The counter stops at 60 so bytes past the minimum frame never match
    always_comb begin
        pay_byte = i_payload.data;
        if (INSERT_HEADERS != 0) begin
            case (cnt_q)
                CNT_W'(IP_LEN_OFS):       pay_byte = hdr_q.ip_len[15:8];
                CNT_W'(IP_LEN_OFS + 1):   pay_byte = hdr_q.ip_len[7:0];
                CNT_W'(IP_CSUM_OFS):      pay_byte = hdr_q.ip_csum[15:8];
                CNT_W'(IP_CSUM_OFS + 1):  pay_byte = hdr_q.ip_csum[7:0];
                CNT_W'(UDP_LEN_OFS):      pay_byte = hdr_q.udp_len[15:8];
                CNT_W'(UDP_LEN_OFS + 1):  pay_byte = hdr_q.udp_len[7:0];
                CNT_W'(UDP_CSUM_OFS):     pay_byte = hdr_q.udp_csum[15:8];
                CNT_W'(UDP_CSUM_OFS + 1): pay_byte = hdr_q.udp_csum[7:0];
                default: ;
            endcase
        end
    end

    // Latched at start since the config block may accept the next word mid frame
    always_ff @(posedge clk) begin
        if (start) begin
            hdr_q <= i_hdr;
        end
    end

    //////////////////////////////
    // Framing state machine
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state_q      <= IDLE;
            cnt_q        <= '0;
            gap_q        <= '0;
            line_valid_q <= 1'b0;
        end else if (state_q == GAP) begin
            // Gap runs on its own once the last FCS byte has left
            if (line_valid_q) begin
                if (i_line_ready) begin
                    line_valid_q <= 1'b0;
                end
            end else if (gap_q >= i_gap_len - 1'b1) begin
                state_q <= IDLE;
            end else begin
                gap_q <= gap_q + 1'b1;
            end
        end else if (adv) begin                     // Back-pressure freezes everything else
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= PREAMBLE;
                        cnt_q   <= '0;
                    end
                end
                PREAMBLE: begin
                    line_valid_q <= 1'b1;
                    if (cnt_q == CNT_W'(PREAMBLE_LEN)) begin
                        line_data_q <= ETH_SFD;     // Eighth beat closes the preamble
                        cnt_q       <= '0;
                        state_q     <= PAYLOAD;
                    end else begin
                        line_data_q <= ETH_PREAMBLE;
                        cnt_q       <= cnt_q + 1'b1;
                    end
                end
                PAYLOAD: begin
                    line_valid_q <= i_payload.valid; // A bubble on input is a bubble on line
                    if (i_payload.valid) begin
                        line_data_q <= pay_byte;
                        if (i_payload.last) begin
                            if (cnt_q >= CNT_W'(MIN_PAYLOAD_LEN - 1)) begin
                                state_q <= FCS;     // Long enough, no padding
                                cnt_q   <= '0;
                            end else begin
                                state_q <= PAD;
                                cnt_q   <= cnt_q + 1'b1;
                            end
                        end else if (cnt_q < CNT_W'(MIN_PAYLOAD_LEN)) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                PAD: begin
                    line_valid_q <= 1'b1;
                    line_data_q  <= ETH_PAD;
                    if (cnt_q == CNT_W'(MIN_PAYLOAD_LEN - 1)) begin
                        state_q <= FCS;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                FCS: begin
                    // CRC stopped updating on the last data beat, so i_fcs is final
                    line_valid_q <= 1'b1;
                    line_data_q  <= i_fcs[cnt_q[1:0]*BYTE_W +: BYTE_W];
                    if (cnt_q == CNT_W'(FCS_LEN - 1)) begin
                        state_q <= GAP;
                        cnt_q   <= '0;
                        gap_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/tx_hdr_config.sv */
`timescale 1ns/1ns

module tx_hdr_config #(
    parameter int INSERT_HEADERS = 1
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  eth_tx_pkg::hdr_word_t        i_hdr,
    input  logic                         i_hdr_valid,
    output logic                         o_hdr_ready,
    input  logic                         i_hdr_take,    // Framer starts a frame with this word
    output logic                         o_hdr_held,
    output eth_tx_pkg::hdr_word_t        o_hdr,
    input  eth_tx_pkg::link_speed_t      i_link_speed,
    output logic [eth_tx_pkg::GAP_W-1:0] o_gap_len
);
    import eth_tx_pkg::*;

    logic             full_q;                       // Holding register owns a word
    logic             ready_q;                      // Registered copy of the empty state
    logic             full_next;
    logic             hdr_hs;                       // Header transfer on this edge
    hdr_word_t        hdr_q;
    logic [GAP_W-1:0] gap_q;

    assign hdr_hs = i_hdr_valid && ready_q;

    // The take strobe only comes while full, so it never meets a transfer
    always_comb begin
        full_next = full_q;
        if (i_hdr_take) begin
            full_next = 1'b0;                       // Framer copied the word at frame start
        end
        if (hdr_hs && INSERT_HEADERS != 0) begin
            full_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            full_q  <= 1'b0;
            ready_q <= 1'b0;                        // Rises on the first edge out of reset
            gap_q   <= gap_table[0];                // Longest gap until the speed is sampled
        end else begin
            full_q  <= full_next;
            ready_q <= !full_next;
            gap_q   <= gap_table[i_link_speed];     // Follows a speed change one cycle later
        end
    end

    // Payload register, only written by a transfer
    always_ff @(posedge clk) begin
        if (hdr_hs && INSERT_HEADERS != 0) begin
            hdr_q <= i_hdr;
        end
    end

    assign o_hdr_ready = ready_q;
    assign o_hdr_held  = (INSERT_HEADERS != 0) ? full_q : 1'b1; // Without insertion never wait
    assign o_hdr       = (INSERT_HEADERS != 0) ? hdr_q : '0;
    assign o_gap_len   = gap_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the Ethernet MAC transmit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_tx_mac \
    -f verilog.f -Mdir obj_dir -o sim_eth_tx_mac
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_eth_tx_mac > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

/* verilog.f */
rtl/eth_tx_pkg.sv
rtl/eth_crc32.sv
rtl/tx_hdr_config.sv
rtl/tx_frame_fsm.sv
rtl/eth_tx_mac.sv
dv/eth_tx_mac_checker.sv
dv/tb_eth_tx_mac.sv
